/* logic/tmr_pkg.sv */
package tmr_pkg;
  // Bus request kind where bit 0 marks a write
  typedef enum logic [1:0] {
    TMR_ACCESS_READ  = 2'b10,
    TMR_ACCESS_WRITE = 2'b11
  } tmr_access;

  localparam int TMR_ACCESS_DATA_BIT = 0;

  typedef enum logic [1:0] {
    TMR_STATUS_OKAY        = 2'b00,
    TMR_STATUS_SLAVE_ERROR = 2'b10
  } tmr_status;

  typedef enum logic [1:0] {
    TMR_CORE_IDLE    = 2'b00,
    TMR_CORE_RUNNING = 2'b01,
    TMR_CORE_DONE    = 2'b10
  } tmr_core_state;

  // Register map
  localparam bit [7:0] TMR_CTRL_OFFSET    = 8'h00;
  localparam bit [7:0] TMR_COMPARE_OFFSET = 8'h04;
  localparam bit [7:0] TMR_COUNT_OFFSET   = 8'h08;
  localparam bit [7:0] TMR_STATUS_OFFSET  = 8'h0C;
  localparam int       TMR_REGISTER_COUNT = 4;

  // CTRL fields
  localparam int TMR_CTRL_ENABLE_BIT     = 0;
  localparam int TMR_CTRL_ONE_SHOT_BIT   = 1;
  localparam int TMR_CTRL_IRQ_ENABLE_BIT = 2;
endpackage

/* logic/tmr_address_decoder.sv */
`timescale 1ns/1ps

module tmr_address_decoder
  import tmr_pkg::*;
#(
  parameter bit                     READABLE             = 1,
  parameter bit                     WRITABLE             = 1,
  parameter int                     ADDRESS_WIDTH        = 8,
  parameter int                     BUS_WIDTH            = 32,
  parameter bit [ADDRESS_WIDTH-1:0] START_ADDRESS        = '0,
  parameter int                     BYTE_SIZE            = 4,
  parameter bit                     USE_ADDITIONAL_MATCH = 0
)(
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  tmr_access                i_access,
  input  logic                     i_additional_match,
  output logic                     o_match
);
  // Byte lanes inside one bus word are not decoded
  localparam int LSB        = $clog2(BUS_WIDTH) - 3;
  localparam int WORD_WIDTH = ADDRESS_WIDTH - LSB;

  localparam bit [ADDRESS_WIDTH-1:0] LAST_BYTE  = START_ADDRESS + ADDRESS_WIDTH'(BYTE_SIZE - 1);
  localparam bit [WORD_WIDTH-1:0]    BEGIN_WORD = START_ADDRESS[ADDRESS_WIDTH-1:LSB];
  localparam bit [WORD_WIDTH-1:0]    END_WORD   = LAST_BYTE[ADDRESS_WIDTH-1:LSB];

  logic [WORD_WIDTH-1:0] word;
  logic                  range_hit;
  logic                  direction_hit;
  logic                  extra_hit;

  assign word = i_address[ADDRESS_WIDTH-1:LSB];

  generate
    if (BEGIN_WORD == END_WORD) begin : g_range
      assign range_hit = word == BEGIN_WORD;
    end else if (BEGIN_WORD == '0 && END_WORD == '1) begin : g_range
      assign range_hit = 1'b1;
    end else if (BEGIN_WORD == '0) begin : g_range
      // Only the upper bound matters
      assign range_hit = word <= END_WORD;
    end else if (END_WORD == '1) begin : g_range
      assign range_hit = word >= BEGIN_WORD;
    end else begin : g_range
      assign range_hit = (word >= BEGIN_WORD) && (word <= END_WORD);
    end

    if (READABLE && WRITABLE) begin : g_direction
      assign direction_hit = 1'b1;
    end else if (READABLE) begin : g_direction
      assign direction_hit = !i_access[TMR_ACCESS_DATA_BIT];
    end else if (WRITABLE) begin : g_direction
      assign direction_hit = i_access[TMR_ACCESS_DATA_BIT];
    end else begin : g_direction
      assign direction_hit = 1'b0;
    end

    if (USE_ADDITIONAL_MATCH) begin : g_extra
      assign extra_hit = i_additional_match;
    end else begin : g_extra
      assign extra_hit = 1'b1;
    end
  endgenerate

  assign o_match = range_hit && direction_hit && extra_hit;
endmodule

/* logic/tmr_register.sv */
`timescale 1ns/1ps

module tmr_register
  import tmr_pkg::*;
#(
  parameter int                     ADDRESS_WIDTH        = 8,
  parameter int                     BUS_WIDTH            = 32,
  parameter bit [ADDRESS_WIDTH-1:0] OFFSET               = '0,
  parameter bit                     READABLE             = 1,
  parameter bit                     WRITABLE             = 1,
  parameter bit                     USE_ADDITIONAL_MATCH = 0,
  parameter bit [BUS_WIDTH-1:0]     RW_MASK              = '0,
  parameter bit [BUS_WIDTH-1:0]     W1C_MASK             = '0
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_request,
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  tmr_access                i_access,
  input  logic [BUS_WIDTH-1:0]     i_write_data,
  input  logic [BUS_WIDTH/8-1:0]   i_strobe,
  input  logic [BUS_WIDTH-1:0]     i_hw_value,
  input  logic [BUS_WIDTH-1:0]     i_hw_set,
  output logic                     o_hit,
  output logic [BUS_WIDTH-1:0]     o_read_data,
  output logic [BUS_WIDTH-1:0]     o_value
);
  localparam bit [BUS_WIDTH-1:0] STORED_MASK = RW_MASK | W1C_MASK;
  localparam int                 LSB         = $clog2(BUS_WIDTH) - 3;

  logic                 match;
  logic                 write_hit;
  logic [BUS_WIDTH-1:0] byte_mask;
  logic [BUS_WIDTH-1:0] rw_write;
  logic [BUS_WIDTH-1:0] w1c_clear;
  logic [BUS_WIDTH-1:0] value_q;

  // Writes with an empty strobe do not match when gated
  tmr_address_decoder #(
    .READABLE             (READABLE),
    .WRITABLE             (WRITABLE),
    .ADDRESS_WIDTH        (ADDRESS_WIDTH),
    .BUS_WIDTH            (BUS_WIDTH),
    .START_ADDRESS        (OFFSET),
    .BYTE_SIZE            (BUS_WIDTH / 8),
    .USE_ADDITIONAL_MATCH (USE_ADDITIONAL_MATCH)
  ) u_decoder (
    .i_address          (i_address),
    .i_access           (i_access),
    .i_additional_match ((|i_strobe) || !i_access[TMR_ACCESS_DATA_BIT]),
    .o_match            (match)
  );

  assign o_hit     = i_request && match;
  assign write_hit = o_hit && i_access[TMR_ACCESS_DATA_BIT];

  always_comb begin
    for (int i = 0; i < BUS_WIDTH / 8; i++) begin
      byte_mask[8*i+:8] = {8{i_strobe[i]}};
    end
  end

  assign rw_write  = write_hit ? (byte_mask & RW_MASK) : '0;
  assign w1c_clear = write_hit ? (i_write_data & byte_mask & W1C_MASK) : '0;

  // Hardware set wins over a clear in the same cycle
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      value_q <= '0;
    end else begin
      value_q <= ((value_q & ~rw_write & ~w1c_clear) | (i_write_data & rw_write)
                  | (i_hw_set & W1C_MASK)) & STORED_MASK;
    end
  end

  assign o_value     = (value_q & STORED_MASK) | (i_hw_value & ~STORED_MASK);
  assign o_read_data = (o_hit && !i_access[TMR_ACCESS_DATA_BIT]) ? o_value : '0;

  // A hit needs a request at this word in a permitted direction
  a_hit_decoded: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    o_hit |-> i_request
              && (i_address[ADDRESS_WIDTH-1:LSB] == OFFSET[ADDRESS_WIDTH-1:LSB])
              && (i_access[TMR_ACCESS_DATA_BIT] ? WRITABLE : READABLE)
  );
endmodule

/* logic/tmr_bus_responder.sv */
`timescale 1ns/1ps

module tmr_bus_responder
  import tmr_pkg::*;
#(
  parameter int BUS_WIDTH = 32
)(
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_request,
  input  logic [TMR_REGISTER_COUNT-1:0] i_hit_vector,
  input  logic [BUS_WIDTH-1:0]          i_read_data_or,
  output logic                          o_response_valid,
  output tmr_status                     o_status,
  output logic [BUS_WIDTH-1:0]          o_read_data
);
  logic                 valid_q;
  tmr_status            status_q;
  logic [BUS_WIDTH-1:0] read_data_q;
  tmr_status            status_d;

  // No register claimed the access
  always_comb begin
    if (|i_hit_vector) begin
      status_d = TMR_STATUS_OKAY;
    end else begin
      status_d = TMR_STATUS_SLAVE_ERROR;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_request;
    end
  end

  // Captured on each request
  always_ff @(posedge i_clk) begin
    if (i_request) begin
      status_q    <= status_d;
      read_data_q <= i_read_data_or;
    end
  end

  assign o_response_valid = valid_q;
  assign o_status         = status_q;
  assign o_read_data      = read_data_q;

  // Register ranges must not overlap
  a_single_hit: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) $onehot0(i_hit_vector)
  );
endmodule

/* logic/tmr_register_block.sv */
`timescale 1ns/1ps

module tmr_register_block
  import tmr_pkg::*;
#(
  parameter int ADDRESS_WIDTH = 8,
  parameter int BUS_WIDTH     = 32
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_request,
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  tmr_access                i_access,
  input  logic [BUS_WIDTH-1:0]     i_write_data,
  input  logic [BUS_WIDTH/8-1:0]   i_strobe,
  output logic                     o_response_valid,
  output tmr_status                o_status,
  output logic [BUS_WIDTH-1:0]     o_read_data,
  input  logic [BUS_WIDTH-1:0]     i_count,
  input  logic                     i_expired,
  output logic                     o_enable,
  output logic                     o_one_shot,
  output logic [BUS_WIDTH-1:0]     o_compare,
  output logic                     o_irq
);
  localparam int STATUS_FLAG_BIT = 0;

  localparam bit [BUS_WIDTH-1:0] CTRL_MASK =
    (BUS_WIDTH'(1) << TMR_CTRL_ENABLE_BIT) | (BUS_WIDTH'(1) << TMR_CTRL_ONE_SHOT_BIT)
    | (BUS_WIDTH'(1) << TMR_CTRL_IRQ_ENABLE_BIT);
  localparam bit [BUS_WIDTH-1:0] FLAG_MASK = BUS_WIDTH'(1) << STATUS_FLAG_BIT;

  localparam bit [ADDRESS_WIDTH-1:0] OFFSETS [TMR_REGISTER_COUNT] = '{
    ADDRESS_WIDTH'(TMR_CTRL_OFFSET), ADDRESS_WIDTH'(TMR_COMPARE_OFFSET),
    ADDRESS_WIDTH'(TMR_COUNT_OFFSET), ADDRESS_WIDTH'(TMR_STATUS_OFFSET)
  };
  localparam bit [BUS_WIDTH-1:0] RW_MASKS [TMR_REGISTER_COUNT] = '{
    CTRL_MASK, '1, '0, '0
  };
  localparam bit [BUS_WIDTH-1:0] W1C_MASKS [TMR_REGISTER_COUNT] = '{
    '0, '0, '0, FLAG_MASK
  };

  logic [TMR_REGISTER_COUNT-1:0] hit;
  logic [BUS_WIDTH-1:0]          read_data [TMR_REGISTER_COUNT];
  logic [BUS_WIDTH-1:0]          value [TMR_REGISTER_COUNT];
  logic [BUS_WIDTH-1:0]          read_data_or;

  // CTRL, COMPARE, COUNT, STATUS in map order
  for (genvar i = 0; i < TMR_REGISTER_COUNT; i++) begin : g_register
    tmr_register #(
      .ADDRESS_WIDTH        (ADDRESS_WIDTH),
      .BUS_WIDTH            (BUS_WIDTH),
      .OFFSET               (OFFSETS[i]),
      .READABLE             (1),
      .WRITABLE             (i != 2),
      .USE_ADDITIONAL_MATCH (i == 3),
      .RW_MASK              (RW_MASKS[i]),
      .W1C_MASK             (W1C_MASKS[i])
    ) u_register (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_request    (i_request),
      .i_address    (i_address),
      .i_access     (i_access),
      .i_write_data (i_write_data),
      .i_strobe     (i_strobe),
      .i_hw_value   ((i == 2) ? i_count : '0),
      .i_hw_set     ((i == 3) ? (FLAG_MASK & {BUS_WIDTH{i_expired}}) : '0),
      .o_hit        (hit[i]),
      .o_read_data  (read_data[i]),
      .o_value      (value[i])
    );
  end

  always_comb begin
    read_data_or = '0;
    for (int i = 0; i < TMR_REGISTER_COUNT; i++) begin
      read_data_or |= read_data[i];
    end
  end

  tmr_bus_responder #(
    .BUS_WIDTH (BUS_WIDTH)
  ) u_responder (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_request        (i_request),
    .i_hit_vector     (hit),
    .i_read_data_or   (read_data_or),
    .o_response_valid (o_response_valid),
    .o_status         (o_status),
    .o_read_data      (o_read_data)
  );

  assign o_enable   = value[0][TMR_CTRL_ENABLE_BIT];
  assign o_one_shot = value[0][TMR_CTRL_ONE_SHOT_BIT];
  assign o_compare  = value[1];
  assign o_irq      = value[3][STATUS_FLAG_BIT] && value[0][TMR_CTRL_IRQ_ENABLE_BIT];
endmodule

/* logic/tmr_counter_core.sv */
`timescale 1ns/1ps

module tmr_counter_core
  import tmr_pkg::*;
#(
  parameter int BUS_WIDTH = 32
)(
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_enable,
  input  logic                 i_one_shot,
  input  logic [BUS_WIDTH-1:0] i_compare,
  output logic [BUS_WIDTH-1:0] o_count,
  output logic                 o_expired
);
  tmr_core_state        state_q;
  logic [BUS_WIDTH-1:0] count_q;
  logic                 reached;

  // Greater-or-equal also catches a compare lowered mid-count
  assign reached   = count_q >= i_compare;
  assign o_expired = (state_q == TMR_CORE_RUNNING) && reached;
  assign o_count   = count_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= TMR_CORE_IDLE;
      count_q <= '0;
    end else if (!i_enable) begin
      state_q <= TMR_CORE_IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        TMR_CORE_IDLE: begin
          state_q <= TMR_CORE_RUNNING;
        end
        TMR_CORE_RUNNING: begin
          if (!reached) begin
            count_q <= count_q + 1'b1;
          end else if (i_one_shot) begin
            state_q <= TMR_CORE_DONE;
            count_q <= i_compare;
          end else begin
            count_q <= '0;
          end
        end
        TMR_CORE_DONE: begin
          // Hold at compare until disabled
          state_q <= TMR_CORE_DONE;
        end
        default: begin
          state_q <= TMR_CORE_IDLE;
          count_q <= '0;
        end
      endcase
    end
  end

  a_one_shot_single_pulse: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_expired && i_one_shot && i_enable) |=> !o_expired
  );

  a_count_bounded: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (state_q == TMR_CORE_RUNNING && $stable(i_compare)) |-> (count_q <= i_compare)
  );
endmodule

/* logic/tmr_top.sv */
`timescale 1ns/1ps

module tmr_top
  import tmr_pkg::*;
#(
  parameter int ADDRESS_WIDTH = 8,
  parameter int BUS_WIDTH     = 32
)(
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_request,
  input  logic [ADDRESS_WIDTH-1:0] i_address,
  input  tmr_access                i_access,
  input  logic [BUS_WIDTH-1:0]     i_write_data,
  input  logic [BUS_WIDTH/8-1:0]   i_strobe,
  output logic                     o_response_valid,
  output tmr_status                o_status,
  output logic [BUS_WIDTH-1:0]     o_read_data,
  output logic                     o_irq
);
  logic                 enable;
  logic                 one_shot;
  logic [BUS_WIDTH-1:0] compare;
  logic [BUS_WIDTH-1:0] count;
  logic                 expired;

  tmr_register_block #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH)
  ) u_register_block (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_request        (i_request),
    .i_address        (i_address),
    .i_access         (i_access),
    .i_write_data     (i_write_data),
    .i_strobe         (i_strobe),
    .o_response_valid (o_response_valid),
    .o_status         (o_status),
    .o_read_data      (o_read_data),
    .i_count          (count),
    .i_expired        (expired),
    .o_enable         (enable),
    .o_one_shot       (one_shot),
    .o_compare        (compare),
    .o_irq            (o_irq)
  );

  tmr_counter_core #(
    .BUS_WIDTH (BUS_WIDTH)
  ) u_counter_core (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_enable   (enable),
    .i_one_shot (one_shot),
    .i_compare  (compare),
    .o_count    (count),
    .o_expired  (expired)
  );
endmodule

/* sim/tmr_tb.sv */
`timescale 1ns/1ps

module tmr_tb
  import tmr_pkg::*;
();
  localparam int ADDRESS_WIDTH    = 8;
  localparam int BUS_WIDTH        = 32;
  localparam int RESPONSE_TIMEOUT = 8;
  localparam int IRQ_TIMEOUT      = 200;
  // Enable, one-shot and irq-enable
  localparam logic [31:0] CTRL_WRITABLE = 32'h0000_0007;

  logic        clk;
  logic        rst_n;
  logic        request;
  logic [7:0]  address;
  tmr_access   access;
  logic [31:0] write_data;
  logic [3:0]  strobe;
  logic        response_valid;
  tmr_status   status;
  logic [31:0] read_data;
  logic        irq;

  int          errors;
  int          timeouts;
  logic [31:0] rng;
  logic [31:0] ctrl_image;
  logic [31:0] compare_image;

  // Expected responses in request order
  tmr_status   status_queue[$];
  logic [31:0] data_queue[$];
  bit          check_queue[$];
  bit          pending_check;
  logic [31:0] pending_data;

  tmr_top #(
    .ADDRESS_WIDTH (ADDRESS_WIDTH),
    .BUS_WIDTH     (BUS_WIDTH)
  ) tmr_top_inst (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_request        (request),
    .i_address        (address),
    .i_access         (access),
    .i_write_data     (write_data),
    .i_strobe         (strobe),
    .o_response_valid (response_valid),
    .o_status         (status),
    .o_read_data      (read_data),
    .o_irq            (irq)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic tmr_status expected_status(input logic [7:0] addr, input tmr_access kind,
                                                input logic [3:0] lanes);
    logic is_write;
    is_write = kind == TMR_ACCESS_WRITE;
    if (addr >= 8'h10) begin
      return TMR_STATUS_SLAVE_ERROR;
    end
    if (is_write && addr[7:2] == TMR_COUNT_OFFSET[7:2]) begin
      return TMR_STATUS_SLAVE_ERROR;
    end
    // Empty strobe never reaches STATUS
    if (is_write && addr[7:2] == TMR_STATUS_OFFSET[7:2] && lanes == 4'h0) begin
      return TMR_STATUS_SLAVE_ERROR;
    end
    return TMR_STATUS_OKAY;
  endfunction

  function automatic logic [31:0] apply_write(input logic [31:0] image, input logic [31:0] data,
                                              input logic [3:0] lanes,
                                              input logic [31:0] writable);
    logic [31:0] result;
    result = image;
    for (int i = 0; i < 4; i++) begin
      if (lanes[i]) begin
        result[8*i+:8] = data[8*i+:8];
      end
    end
    return result & writable;
  endfunction

  task automatic check_status(input string name, input tmr_status expected,
                              input tmr_status actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && response_valid) begin
      if (status_queue.size() == 0) begin
        $display("%0t ns: a response arrived with no request pending", $time);
        errors++;
      end else begin
        check_status("o_status", status_queue.pop_front(), status);
        pending_check = check_queue.pop_front();
        pending_data  = data_queue.pop_front();
        if (pending_check) begin
          check_data("o_read_data", pending_data, read_data);
        end
      end
    end
  end

  task automatic bus_access(input tmr_access kind, input logic [7:0] addr,
                            input logic [31:0] data, input logic [3:0] lanes,
                            input bit check_read, input logic [31:0] expected_data,
                            output logic [31:0] result);
    int waited;
    @(posedge clk);
    request    <= 1'b1;
    address    <= addr;
    access     <= kind;
    write_data <= data;
    strobe     <= lanes;
    status_queue.push_back(expected_status(addr, kind, lanes));
    data_queue.push_back(expected_data);
    check_queue.push_back(check_read);
    @(posedge clk);
    request <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!response_valid && waited < RESPONSE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!response_valid) begin
      $display("%0t ns: no bus response for address %h", $time, addr);
      timeouts++;
    end else if (waited != 0) begin
      $display("%0t ns: response for address %h came %0d cycles late", $time, addr, waited);
      errors++;
    end
    result = read_data;
  endtask

  task automatic write_word(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes);
    logic [31:0] unused;
    bus_access(TMR_ACCESS_WRITE, addr, data, lanes, 1'b0, 32'h0, unused);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected);
    logic [31:0] unused;
    bus_access(TMR_ACCESS_READ, addr, 32'h0, 4'hf, 1'b1, expected, unused);
  endtask

  task automatic wait_for_irq(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!irq && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!irq) begin
      $display("%0t ns: o_irq did not rise within %0d cycles", $time, limit);
      timeouts++;
    end
  endtask

  initial begin
    logic [31:0] value;
    logic [7:0]  target;
    logic [3:0]  lanes;
    errors = 0;
    timeouts = 0;
    rng = 32'hea7b_03a8;
    ctrl_image = 32'h0;
    compare_image = 32'h0;
    rst_n = 1'b0;
    request = 1'b0;
    address = 8'h0;
    access = TMR_ACCESS_READ;
    write_data = 32'h0;
    strobe = 4'h0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Strobed writes to CTRL and COMPARE with the timer kept off
    for (int n = 0; n < 16; n++) begin
      rng = xorshift(rng);
      lanes = rng[3:0];
      rng = xorshift(rng);
      if (n % 2 == 0) begin
        value = rng & ~(32'h1 << TMR_CTRL_ENABLE_BIT);
        write_word(TMR_CTRL_OFFSET, value, lanes);
        ctrl_image = apply_write(ctrl_image, value, lanes, CTRL_WRITABLE);
        read_expect(TMR_CTRL_OFFSET, ctrl_image);
      end else begin
        write_word(TMR_COMPARE_OFFSET, rng, lanes);
        compare_image = apply_write(compare_image, rng, lanes, 32'hffff_ffff);
        read_expect(TMR_COMPARE_OFFSET, compare_image);
      end
    end

    // Unmapped and illegal accesses
    rng = xorshift(rng);
    target = 8'h10 + 8'(rng % 32'd240);
    bus_access(TMR_ACCESS_READ, target, 32'h0, 4'hf, 1'b0, 32'h0, value);
    write_word(target, rng, 4'hf);
    bus_access(TMR_ACCESS_READ, 8'hfc, 32'h0, 4'hf, 1'b0, 32'h0, value);
    write_word(8'hfc, rng, 4'hf);
    write_word(TMR_COUNT_OFFSET, rng, 4'hf);
    write_word(TMR_STATUS_OFFSET, 32'h1, 4'h0);
    read_expect(TMR_CTRL_OFFSET, ctrl_image);
    read_expect(TMR_COMPARE_OFFSET, compare_image);
    read_expect(TMR_COUNT_OFFSET, 32'h0);
    read_expect(TMR_STATUS_OFFSET, 32'h0);

    // Periodic mode
    compare_image = 32'd5;
    write_word(TMR_COMPARE_OFFSET, compare_image, 4'hf);
    ctrl_image = 32'h5;
    write_word(TMR_CTRL_OFFSET, ctrl_image, 4'hf);
    wait_for_irq(IRQ_TIMEOUT);
    bus_access(TMR_ACCESS_READ, TMR_COUNT_OFFSET, 32'h0, 4'hf, 1'b0, 32'h0, value);
    if (value > compare_image) begin
      $display("%0t ns: COUNT read %0d, above compare %0d", $time, value, compare_image);
      errors++;
    end

    // Stop the timer, then clear the flag
    ctrl_image = 32'h4;
    write_word(TMR_CTRL_OFFSET, ctrl_image, 4'hf);
    if (!irq) begin
      $display("%0t ns: o_irq fell before STATUS was cleared", $time);
      errors++;
    end
    write_word(TMR_STATUS_OFFSET, 32'h1, 4'h1);
    if (irq) begin
      $display("%0t ns: o_irq still high in the STATUS clear response", $time);
      errors++;
    end
    read_expect(TMR_STATUS_OFFSET, 32'h0);

    // One-shot mode holds at compare
    compare_image = 32'd7;
    write_word(TMR_COMPARE_OFFSET, compare_image, 4'hf);
    ctrl_image = 32'h7;
    write_word(TMR_CTRL_OFFSET, ctrl_image, 4'hf);
    wait_for_irq(IRQ_TIMEOUT);
    read_expect(TMR_COUNT_OFFSET, compare_image);
    repeat (10) @(posedge clk);
    read_expect(TMR_COUNT_OFFSET, compare_image);
    ctrl_image = 32'h6;
    write_word(TMR_CTRL_OFFSET, ctrl_image, 4'hf);
    read_expect(TMR_COUNT_OFFSET, 32'h0);

    repeat (2) @(posedge clk);
    $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end
endmodule

/* compile.f */
logic/tmr_pkg.sv
logic/tmr_address_decoder.sv
logic/tmr_register.sv
logic/tmr_bus_responder.sv
logic/tmr_register_block.sv
logic/tmr_counter_core.sv
logic/tmr_top.sv
sim/tmr_tb.sv

/* Makefile */
SOURCES := compile.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtmr_tb: $(SOURCES)
	verilator --binary --timing --assert -f compile.f --top-module tmr_tb \
		-Mdir obj_dir -o Vtmr_tb

run: obj_dir/Vtmr_tb
	./obj_dir/Vtmr_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "TEST OK" sim.log && ! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
